// File: sys_pkg.sv
package sys_pkg;

    // bus and memory widths
    typedef logic [15:0] addr_t;      // cpu address
    typedef logic [7:0]  byte_t;      // data byte
    typedef logic [11:0] mem_addr_t;  // 4k rom/ram word address

    // multicycle cpu states
    typedef enum logic [2:0] {
        RESET_LO,   // read vector low byte
        RESET_HI,   // read vector high byte
        FETCH,      // opcode on rdata
        OPERAND1,   // first operand byte on rdata
        OPERAND2,   // second operand byte on rdata
        READ,       // absolute data on rdata
        WRITE,      // store strobe out
        BRANCH      // load branch target
    } cpu_state_t;

    // cpu bus, driven by the core only
    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  we;    // one enabled cycle wide
    } cpu_bus_t;

    // i/o register map
    localparam addr_t IO_SW_LSB    = 16'h2000;
    localparam addr_t IO_SW_MSB    = 16'h2001;
    localparam addr_t IO_BTN       = 16'h2002;
    localparam addr_t IO_LED_LSB   = 16'h2010;
    localparam addr_t IO_LED_MSB   = 16'h2011;
    localparam addr_t IO_DISP0     = 16'h2020;
    localparam addr_t IO_DISP1     = 16'h2021;
    localparam addr_t IO_DISP2     = 16'h2022;
    localparam addr_t IO_DISP3     = 16'h2023;
    localparam addr_t IO_DISP_CTRL = 16'h2024;

    localparam addr_t RAM_BASE     = 16'he000;  // 4k window

endpackage

// File: cpu_core.sv
module cpu_core (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cpu_en,  // half-rate step enable
    output sys_pkg::cpu_bus_t bus,
    input  sys_pkg::byte_t    rdata
);
    import sys_pkg::*;

    // supported opcodes, anything else is a 1-byte nop
    localparam byte_t OP_LDA_IMM = 8'ha9;
    localparam byte_t OP_LDA_ABS = 8'had;
    localparam byte_t OP_STA_ABS = 8'h8d;
    localparam byte_t OP_ADC_IMM = 8'h69;
    localparam byte_t OP_ADC_ABS = 8'h6d;
    localparam byte_t OP_EOR_IMM = 8'h49;
    localparam byte_t OP_CLC     = 8'h18;
    localparam byte_t OP_JMP_ABS = 8'h4c;
    localparam byte_t OP_BEQ     = 8'hf0;
    localparam byte_t OP_BNE     = 8'hd0;

    localparam addr_t RESET_VEC  = 16'hfffc;

    cpu_state_t state;
    byte_t      acc;
    addr_t      pc;        // address of the byte now on the bus during fetch
    addr_t      operand;   // abs low byte or branch target
    byte_t      opcode;
    logic       z_flag;
    logic       c_flag;

    addr_t      pc_inc;
    addr_t      abs_target;
    logic [8:0] sum;
    byte_t      alu_res;
    logic       alu_c;
    logic       br_taken;

    assign pc_inc     = pc + 16'd1;
    assign abs_target = {rdata, operand[7:0]};  // high byte arrives last

    // alu works on the byte currently on rdata
    always_comb begin
        sum     = {1'b0, acc} + {1'b0, rdata} + {8'd0, c_flag};
        alu_res = acc;
        alu_c   = c_flag;
        case (opcode)
            OP_LDA_IMM, OP_LDA_ABS: alu_res = rdata;
            OP_ADC_IMM, OP_ADC_ABS: begin
                alu_res = sum[7:0];
                alu_c   = sum[8];  // carry out
            end
            OP_EOR_IMM: alu_res = acc ^ rdata;
            default:    alu_res = acc;
        endcase
    end

    assign br_taken = (opcode == OP_BEQ) ? z_flag : !z_flag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RESET_LO;
            bus.addr  <= RESET_VEC;  // vector low byte first
            bus.wdata <= '0;
            bus.we    <= 1'b0;
            pc        <= '0;
            acc       <= '0;
            operand   <= '0;
            opcode    <= '0;
            z_flag    <= 1'b0;
            c_flag    <= 1'b0;
        end else if (cpu_en) begin
            case (state)
                RESET_LO: begin
                    pc[7:0]  <= rdata;
                    bus.addr <= RESET_VEC + 16'd1;
                    state    <= RESET_HI;
                end
                RESET_HI: begin
                    pc       <= {rdata, pc[7:0]};
                    bus.addr <= {rdata, pc[7:0]};
                    state    <= FETCH;
                end
                FETCH: begin
                    pc       <= pc_inc;
                    bus.addr <= pc_inc;
                    case (rdata)
                        OP_CLC: c_flag <= 1'b0;  // single cycle
                        OP_LDA_IMM, OP_ADC_IMM, OP_EOR_IMM,
                        OP_LDA_ABS, OP_ADC_ABS, OP_STA_ABS,
                        OP_JMP_ABS, OP_BEQ, OP_BNE: begin
                            opcode <= rdata;
                            state  <= OPERAND1;
                        end
                        default: state <= FETCH;  // unknown, skip one byte
                    endcase
                end
                OPERAND1: begin
                    case (opcode)
                        OP_LDA_IMM, OP_ADC_IMM, OP_EOR_IMM: begin
                            acc      <= alu_res;
                            z_flag   <= (alu_res == 8'd0);
                            c_flag   <= alu_c;
                            pc       <= pc_inc;
                            bus.addr <= pc_inc;
                            state    <= FETCH;
                        end
                        OP_BEQ, OP_BNE: begin
                            if (br_taken) begin
                                // offset relative to the next instruction
                                operand <= pc_inc + {{8{rdata[7]}}, rdata};
                                state   <= BRANCH;
                            end else begin
                                pc       <= pc_inc;
                                bus.addr <= pc_inc;
                                state    <= FETCH;
                            end
                        end
                        default: begin
                            operand[7:0] <= rdata;
                            pc           <= pc_inc;
                            bus.addr     <= pc_inc;
                            state        <= OPERAND2;
                        end
                    endcase
                end
                OPERAND2: begin
                    if (opcode == OP_JMP_ABS) begin
                        pc       <= abs_target;
                        bus.addr <= abs_target;
                        state    <= FETCH;
                    end else if (opcode == OP_STA_ABS) begin
                        pc        <= pc_inc;
                        bus.addr  <= abs_target;
                        bus.wdata <= acc;
                        bus.we    <= 1'b1;  // strobe for one enabled cycle
                        state     <= WRITE;
                    end else begin
                        pc       <= pc_inc;
                        bus.addr <= abs_target;  // data read next
                        state    <= READ;
                    end
                end
                READ: begin
                    acc      <= alu_res;
                    z_flag   <= (alu_res == 8'd0);
                    c_flag   <= alu_c;
                    bus.addr <= pc;
                    state    <= FETCH;
                end
                WRITE: begin
                    bus.we   <= 1'b0;
                    bus.addr <= pc;
                    state    <= FETCH;
                end
                BRANCH: begin
                    pc       <= operand;
                    bus.addr <= operand;
                    state    <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

endmodule

// File: rom_sync.sv
module rom_sync (
    input  logic                clk,
    input  sys_pkg::mem_addr_t  addr,
    output sys_pkg::byte_t      rdata
);
    import sys_pkg::*;

    byte_t mem [4096];  // 4k program store

    // program image, 2-digit hex per line
    initial begin
        $readmemh("program.hex", mem);
    end

    // one clk read latency, runs every clk
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// File: ram_sync.sv
module ram_sync (
    input  logic                clk,
    input  sys_pkg::mem_addr_t  addr,
    input  sys_pkg::byte_t      wdata,
    input  logic                we,
    output sys_pkg::byte_t      rdata
);
    import sys_pkg::*;

    byte_t mem [4096];

    // read before write, old data on a collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: basic_io.sv
module basic_io #(
    parameter int SCAN_DIV = 64  // enabled cycles per digit
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_en,
    input  logic              io_sel,
    input  sys_pkg::cpu_bus_t bus,
    output sys_pkg::byte_t    rdata,
    input  logic [15:0]       sw,
    input  logic [4:0]        btn,
    output logic [15:0]       led,
    output logic [6:0]        seg,
    output logic              dp,
    output logic [3:0]        an
);
    import sys_pkg::*;

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    byte_t            led_lsb;
    byte_t            led_msb;
    byte_t            disp [4];   // {dp,seg}, active low
    byte_t            disp_ctrl;  // bit 0 enables scanning
    logic [CNT_W-1:0] scan_cnt;
    logic [1:0]       digit;

    // register writes, one per store strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_lsb   <= '0;
            led_msb   <= '0;
            disp_ctrl <= '0;
            for (int i = 0; i < 4; i++) begin
                disp[i] <= 8'hff;  // blank
            end
        end else if (cpu_en && io_sel && bus.we) begin
            case (bus.addr)
                IO_LED_LSB:   led_lsb   <= bus.wdata;
                IO_LED_MSB:   led_msb   <= bus.wdata;
                IO_DISP0:     disp[0]   <= bus.wdata;
                IO_DISP1:     disp[1]   <= bus.wdata;
                IO_DISP2:     disp[2]   <= bus.wdata;
                IO_DISP3:     disp[3]   <= bus.wdata;
                IO_DISP_CTRL: disp_ctrl <= bus.wdata;
                default:      led_lsb   <= led_lsb;  // read-only or unmapped
            endcase
        end
    end

    // read path clocked every clk, same latency as rom and ram
    always_ff @(posedge clk) begin
        case (bus.addr)
            IO_SW_LSB:    rdata <= sw[7:0];
            IO_SW_MSB:    rdata <= sw[15:8];
            IO_BTN:       rdata <= {3'd0, btn};
            IO_LED_LSB:   rdata <= led_lsb;
            IO_LED_MSB:   rdata <= led_msb;
            IO_DISP0:     rdata <= disp[0];
            IO_DISP1:     rdata <= disp[1];
            IO_DISP2:     rdata <= disp[2];
            IO_DISP3:     rdata <= disp[3];
            IO_DISP_CTRL: rdata <= disp_ctrl;
            default:      rdata <= '0;
        endcase
    end

    // digit scanner, parked on digit 0 while disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (cpu_en) begin
            if (!disp_ctrl[0]) begin
                scan_cnt <= '0;
                digit    <= '0;
            end else if (scan_cnt == CNT_W'(SCAN_DIV - 1)) begin
                scan_cnt <= '0;
                digit    <= digit + 2'd1;  // wraps 3 -> 0
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    assign led       = {led_msb, led_lsb};
    assign an        = disp_ctrl[0] ? ~(4'b0001 << digit) : 4'hf;  // one anode low
    assign {dp, seg} = disp[digit];

endmodule

// File: system_top.sv
module system_top #(
    parameter int SCAN_DIV = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] sw,
    input  logic [4:0]  btn,   // plain inputs, reset comes from rst_n
    output logic [15:0] led,
    output logic [6:0]  seg,
    output logic        dp,
    output logic [3:0]  an
);
    import sys_pkg::*;

    typedef struct packed {
        logic rom;
        logic ram;
        logic io;
    } mem_sel_t;

    logic      cpu_en;   // cpu and i/o step on every other clk
    cpu_bus_t  cpu_bus;
    byte_t     cpu_rdata;
    byte_t     rom_rdata;
    byte_t     ram_rdata;
    byte_t     io_rdata;
    mem_addr_t mem_addr;
    mem_sel_t  sel;
    mem_sel_t  sel_q;    // lines up with the one-clk read latency

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_en <= 1'b0;
            sel_q  <= '0;
        end else begin
            cpu_en <= !cpu_en;
            sel_q  <= sel;
        end
    end

    // memory map decode
    assign sel.rom  = (cpu_bus.addr[15:12] == 4'h0);                 // 0x0xxx
    assign sel.io   = (cpu_bus.addr[15:8]  == IO_SW_LSB[15:8]);      // 0x20xx
    assign sel.ram  = (cpu_bus.addr[15:12] == RAM_BASE[15:12]);      // 0xexxx
    assign mem_addr = cpu_bus.addr[11:0];

    // unmapped reads give zero, so the reset vector is 0x0000
    assign cpu_rdata = sel_q.rom ? rom_rdata :
                       sel_q.io  ? io_rdata  :
                       sel_q.ram ? ram_rdata : 8'h00;

    cpu_core u_cpu (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu_en (cpu_en),
        .bus    (cpu_bus),
        .rdata  (cpu_rdata)
    );

    rom_sync u_rom (
        .clk   (clk),
        .addr  (mem_addr),
        .rdata (rom_rdata)
    );

    ram_sync u_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (cpu_bus.wdata),
        .we    (cpu_bus.we && sel.ram),
        .rdata (ram_rdata)
    );

    basic_io #(
        .SCAN_DIV (SCAN_DIV)
    ) u_io (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu_en (cpu_en),
        .io_sel (sel.io),
        .bus    (cpu_bus),
        .rdata  (io_rdata),
        .sw     (sw),
        .btn    (btn),
        .led    (led),
        .seg    (seg),
        .dp     (dp),
        .an     (an)
    );

endmodule

// File: system_props.sv
module system_props (
    input logic              clk,
    input logic              rst_n,
    input sys_pkg::cpu_bus_t cpu_bus,
    input logic [3:0]        an
);

    // at most one digit driven at a time
    an_one_low: assert property (@(posedge clk) disable iff (!rst_n)
        (an == 4'hf) || $onehot(~an))
        else $error("anode vector %b drives more than one digit", an);

    // a store strobe covers one enabled cycle, i.e. two clk
    we_single: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_bus.we && $past(cpu_bus.we) && $past(cpu_bus.we, 2)))
        else $error("write strobe held over two enabled cycles at %h", cpu_bus.addr);

    // rom lives at 0x0xxx and is never a store target
    no_rom_write: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_bus.we |-> (cpu_bus.addr[15:12] != 4'h0))
        else $error("store into rom range at %h", cpu_bus.addr);

endmodule

bind system_top system_props u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_bus (cpu_bus),
    .an      (an)
);

// File: tb_checker.sv
module tb_checker #(
    parameter int SCAN_DIV   = 8,
    parameter int WAIT_BOUND = 400  // clk allowed for led to settle
) (
    input  logic            clk,
    input  logic [15:0]     led,
    input  logic [6:0]      seg,
    input  logic            dp,
    input  logic [3:0]      an,
    input  logic            start,       // one clk wide, expectation valid
    input  logic            reset_mode,  // idle outputs only
    input  logic [15:0]     exp_led,
    input  logic [3:0][7:0] exp_disp,    // {dp,seg} per digit
    output logic            busy,
    output int              err_cnt
);
    localparam int SCAN_CLKS = 8 * SCAN_DIV;  // 4 digits x 2 clk per enabled cycle
    localparam int MAX_SCANS = 4;             // display writes may trail the led

    logic [3:0]      seen;    // digit was active in the last scan
    logic [3:0]      wrong;   // any sample of that digit mismatched
    logic            bad_an;
    logic [3:0][7:0] got;

    // one full turn of the scanner, sampled mid-cycle
    task automatic sample_scan();
        int n;
        int d;
        seen   = '0;
        wrong  = '0;
        bad_an = 1'b0;
        got    = '0;
        for (n = 0; n < SCAN_CLKS; n++) begin
            @(negedge clk);
            if ($onehot(~an)) begin
                for (d = 0; d < 4; d++) begin
                    if (!an[d]) begin
                        seen[d] = 1'b1;
                        got[d]  = {dp, seg};
                        if ({dp, seg} !== exp_disp[d]) begin
                            wrong[d] = 1'b1;
                        end
                    end
                end
            end else begin
                bad_an = 1'b1;  // blank or several digits while scanning
            end
        end
    endtask

    task automatic report_scan();
        int d;
        if (bad_an) begin
            $display("anodes were not one-hot low for the whole scan, at time %0t", $time);
        end
        for (d = 0; d < 4; d++) begin
            if (!seen[d]) begin
                $display("digit %0d was never active during a full scan, at time %0t",
                         d, $time);
            end else if (wrong[d]) begin
                $display("ERR %0t: digit %0d shows %h, expected %h",
                         $time, d, got[d], exp_disp[d]);
            end
        end
    endtask

    task automatic check_idle();
        @(negedge clk);
        if (led !== exp_led || an !== 4'hf) begin
            $display("ERR %0t: after reset led=%h an=%b, expected led=%h an=1111",
                     $time, led, an, exp_led);
            err_cnt++;
        end
    endtask

    task automatic check_outputs();
        int  waited;
        int  scans;
        logic good;
        waited = 0;
        scans  = 0;
        good   = 1'b0;
        // led low byte is the last store of a pass
        do begin
            @(negedge clk);
            waited++;
        end while (led !== exp_led && waited < WAIT_BOUND);
        if (led !== exp_led) begin
            $display("timeout: led stayed at %h and did not reach %h within %0d clk",
                     led, exp_led, WAIT_BOUND);
            err_cnt++;
        end else begin
            while (!good && scans < MAX_SCANS) begin
                sample_scan();
                good = (seen == 4'hf) && (wrong == 4'h0) && !bad_an;
                scans++;
            end
            if (!good) begin
                report_scan();
                err_cnt++;
            end
        end
    endtask

    initial begin
        busy    = 1'b0;
        err_cnt = 0;
        forever begin
            @(posedge clk);
            if (start) begin
                busy = 1'b1;
                if (reset_mode) begin
                    check_idle();
                end else begin
                    check_outputs();
                end
                busy = 1'b0;
            end
        end
    end

endmodule

// File: tb_system.sv
module tb_system;

    localparam int          SCAN_DIV  = 8;
    localparam int          NUM_TESTS = 6;
    localparam int          RUN_LIMIT = NUM_TESTS * 1000;  // clk
    localparam logic [31:0] SEED      = 32'hbe32e6ce;

    typedef struct packed {
        logic [15:0]     led;
        logic [3:0][7:0] disp;  // {dp,seg}, digit 3 down to 0
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic [15:0] sw;
    logic [4:0]  btn;
    logic [15:0] led;
    logic [6:0]  seg;
    logic        dp;
    logic [3:0]  an;

    logic        start;
    logic        reset_mode;
    expect_t     exp_q;     // what the checker compares against
    logic        busy;
    int          err_cnt;
    int          cycle_cnt;
    int          tests_passed;
    int          tests_failed;
    int unsigned seed_val;
    logic [15:0] last_led;  // new stimulus always moves the led

    system_top #(
        .SCAN_DIV (SCAN_DIV)
    ) UUT (
        .clk   (clk),
        .rst_n (rst_n),
        .sw    (sw),
        .btn   (btn),
        .led   (led),
        .seg   (seg),
        .dp    (dp),
        .an    (an)
    );

    tb_checker #(
        .SCAN_DIV   (SCAN_DIV),
        .WAIT_BOUND (400)
    ) chk (
        .clk        (clk),
        .led        (led),
        .seg        (seg),
        .dp         (dp),
        .an         (an),
        .start      (start),
        .reset_mode (reset_mode),
        .exp_led    (exp_q.led),
        .exp_disp   (exp_q.disp),
        .busy       (busy),
        .err_cnt    (err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < RUN_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run stopped after %0d clk cycles without finishing the tests", RUN_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    // what the rom program should leave on the outputs
    function automatic expect_t expected_outputs(input logic [15:0] sw_v,
                                                 input logic [4:0]  btn_v);
        expect_t    e;
        logic [8:0] sum;
        sum       = {1'b0, sw_v[7:0]} + {1'b0, sw_v[15:8]};
        e.led     = {7'd0, sum};
        e.disp[0] = sum[7:0];
        e.disp[1] = {3'd0, btn_v} ^ 8'h1f;
        e.disp[2] = 8'hff;  // never written, stays blank
        e.disp[3] = 8'hff;
        return e;
    endfunction

    // mode 0 no carry, 1 carry, 2 anything; sum differs from the shown led
    function automatic logic [15:0] pick_sw(input int mode, input logic [15:0] prev_led);
        int lo;
        int hi;
        do begin
            if (mode == 1) begin
                lo = $urandom_range(255, 1);
                hi = $urandom_range(255, 256 - lo);
            end else if (mode == 0) begin
                lo = $urandom_range(255, 0);
                hi = $urandom_range(255 - lo, 0);
            end else begin
                lo = $urandom_range(255, 0);
                hi = $urandom_range(255, 0);
            end
        end while (16'(lo + hi) == prev_led);
        return {8'(hi), 8'(lo)};
    endfunction

    task automatic drive_inputs(input logic [15:0] sw_v, input logic [4:0] btn_v);
        @(posedge clk);
        #1;
        sw  = sw_v;
        btn = btn_v;
    endtask

    // hand the expectation to the checker and wait until it is done
    task automatic run_check(input logic idle);
        @(posedge clk);
        #1;
        exp_q      = idle ? '0 : expected_outputs(sw, btn);
        reset_mode = idle;
        start      = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        last_led = exp_q.led;
    endtask

    task automatic close_test(input int num, input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_passed++;
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d checks wrong", num, name, err_cnt - errs_before);
        end
    endtask

    initial begin : sequencer
        int errs;
        int i;
        sw           = '0;
        btn          = '0;
        rst_n        = 1'b0;
        start        = 1'b0;
        reset_mode   = 1'b0;
        exp_q        = '0;
        tests_passed = 0;
        tests_failed = 0;
        last_led     = '0;
        seed_val     = $urandom(SEED);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs = err_cnt;
        run_check(1'b1);  // before the first store
        close_test(1, "reset state", errs);

        errs = err_cnt;
        drive_inputs(16'h0000, 5'd0);
        run_check(1'b0);
        close_test(2, "zero inputs", errs);

        errs = err_cnt;
        for (i = 0; i < 2; i++) begin
            drive_inputs(pick_sw(0, last_led), btn);
            run_check(1'b0);
        end
        close_test(3, "sum without carry", errs);

        errs = err_cnt;
        for (i = 0; i < 2; i++) begin
            drive_inputs(pick_sw(1, last_led), btn);
            run_check(1'b0);
        end
        close_test(4, "sum with carry", errs);

        // switches move too so the led marks the new pass
        errs = err_cnt;
        for (i = 0; i < 3; i++) begin
            drive_inputs(pick_sw(2, last_led), 5'($urandom_range(31, 0)));
            run_check(1'b0);
        end
        close_test(5, "buttons and scan", errs);

        errs = err_cnt;
        for (i = 0; i < 4; i++) begin
            drive_inputs(pick_sw(2, last_led), btn);
            run_check(1'b0);
        end
        close_test(6, "back-to-back changes", errs);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: program.hex
// readmemh image from address 0x000, the bytes of one instruction per line
// after the slashes: byte address, then the instruction
a9 01       // 000 lda #$01
8d 24 20    // 002 sta $2024   scanner on
18          // 005 clc         loop start
ad 00 20    // 006 lda $2000   switch low byte
6d 01 20    // 009 adc $2001   plus switch high byte
8d 00 e0    // 00c sta $e000   sum kept in ram
ad 00 e0    // 00f lda $e000   read back
8d 20 20    // 012 sta $2020   digit 0
ad 02 20    // 015 lda $2002   buttons
49 1f       // 018 eor #$1f
8d 21 20    // 01a sta $2021   digit 1
a9 00       // 01d lda #$00
69 00       // 01f adc #$00    carry into bit 0
8d 11 20    // 021 sta $2011   led high byte
ad 00 e0    // 024 lda $e000
8d 10 20    // 027 sta $2010   led low byte, written last
d0 d9       // 02a bne $0005
4c 05 00    // 02c jmp $0005   zero sum falls through to here

// File: src.f
sys_pkg.sv
cpu_core.sv
rom_sync.sv
ram_sync.sv
basic_io.sv
system_top.sv
system_props.sv
tb_checker.sv
tb_system.sv

// File: run.sh
#!/bin/sh
# build and run the system testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_system -f src.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0
